/* vec_settings.svh */
`ifndef VEC_SETTINGS_SVH
`define VEC_SETTINGS_SVH

// Vector shape
`define VEC_LANES     4
`define VEC_LANE_W    16

// Register file size
`define VEC_REGS      16

// Local memory depth in whole vectors
`define VEC_MEM_DEPTH 256

`endif

/* vec_pkg.sv */
`include "vec_settings.svh"

package vec_pkg;

    typedef logic [`VEC_LANE_W-1:0] lane_t;
    typedef lane_t [`VEC_LANES-1:0] vec_t;

    typedef logic [$clog2(`VEC_REGS)-1:0]      reg_addr_t;
    typedef logic [$clog2(`VEC_MEM_DEPTH)-1:0] mem_addr_t;

    // opcode 31..28, vd 27..24, vs1 23..20, vs2 19..16, imm 15..0
    typedef logic [31:0] instr_t;

    typedef enum logic [3:0] {
        OP_NOP    = 4'h0,
        OP_VLI    = 4'h1,
        OP_VADD   = 4'h2,
        OP_VSUB   = 4'h3,
        OP_VMUL   = 4'h4,
        OP_VMAX   = 4'h5,
        OP_VBCAST = 4'h6,
        OP_VREV   = 4'h7,
        OP_VLOAD  = 4'h8,
        OP_VSTORE = 4'h9
    } opcode_e;

    typedef struct packed {
        opcode_e   opcode;
        reg_addr_t vd;
        reg_addr_t vs1;
        reg_addr_t vs2;
        lane_t     imm;
        logic      reg_we;
        logic      mem_we;
        logic      mem_re;
    } ctrl_t;

    typedef struct packed {
        ctrl_t ctrl;
        vec_t  a;
        vec_t  b;
        vec_t  c;
    } ex_stage_t;

    typedef struct packed {
        reg_addr_t vd;
        logic      reg_we;
        logic      mem_re;
        vec_t      result;
    } mem_stage_t;

    typedef struct packed {
        reg_addr_t vd;
        vec_t      data;
    } wb_t;

endpackage

/* vec_decoder.sv */
`timescale 1ns/1ns

module vec_decoder (
    input  vec_pkg::instr_t    instr,
    input  vec_pkg::reg_addr_t ex_vd,
    input  logic               ex_we,
    input  vec_pkg::reg_addr_t mem_vd,
    input  logic               mem_we,
    output vec_pkg::ctrl_t     ctrl,
    output logic               stall
);

    vec_pkg::opcode_e op;
    logic             use_vs1;
    logic             use_vs2;
    logic             use_vd;

    // Destination still owned by an instruction in EX or MEM
    function automatic logic in_flight(input vec_pkg::reg_addr_t r);
        return (ex_we && ex_vd == r) || (mem_we && mem_vd == r);
    endfunction

    assign op = vec_pkg::opcode_e'(instr[31:28]);

    always_comb begin
        ctrl.opcode = op;
        ctrl.vd     = instr[27:24];
        ctrl.vs1    = instr[23:20];
        ctrl.vs2    = instr[19:16];
        ctrl.imm    = instr[15:0];
        ctrl.reg_we = 1'b0;
        ctrl.mem_we = 1'b0;
        ctrl.mem_re = 1'b0;
        use_vs1     = 1'b0;
        use_vs2     = 1'b0;
        use_vd      = 1'b0;
        case (op)
            vec_pkg::OP_VLI: begin
                ctrl.reg_we = 1'b1;
            end
            vec_pkg::OP_VADD, vec_pkg::OP_VSUB, vec_pkg::OP_VMUL, vec_pkg::OP_VMAX: begin
                ctrl.reg_we = 1'b1;
                use_vs1     = 1'b1;
                use_vs2     = 1'b1;
            end
            vec_pkg::OP_VBCAST, vec_pkg::OP_VREV: begin
                ctrl.reg_we = 1'b1;
                use_vs1     = 1'b1;
            end
            vec_pkg::OP_VLOAD: begin
                ctrl.reg_we = 1'b1;
                ctrl.mem_re = 1'b1;
            end
            // Store source is named by vd
            vec_pkg::OP_VSTORE: begin
                ctrl.mem_we = 1'b1;
                use_vd      = 1'b1;
            end
            default: begin
                ctrl.opcode = vec_pkg::OP_NOP;
            end
        endcase
    end

    always_comb begin
        stall = (use_vs1 && in_flight(ctrl.vs1)) ||
                (use_vs2 && in_flight(ctrl.vs2)) ||
                (use_vd  && in_flight(ctrl.vd));
    end

endmodule

/* vec_regfile.sv */
`timescale 1ns/1ns

`include "vec_settings.svh"

module vec_regfile (
    input  logic               clk,
    input  logic               rst,
    input  logic               we,
    input  vec_pkg::reg_addr_t waddr,
    input  vec_pkg::vec_t      wdata,
    input  vec_pkg::reg_addr_t raddr1,
    input  vec_pkg::reg_addr_t raddr2,
    input  vec_pkg::reg_addr_t raddr3,
    output vec_pkg::vec_t      rdata1,
    output vec_pkg::vec_t      rdata2,
    output vec_pkg::vec_t      rdata3
);

    vec_pkg::vec_t regs [`VEC_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `VEC_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // Write-through so a reader in ID sees the WB value this cycle
    assign rdata1 = (we && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (we && waddr == raddr2) ? wdata : regs[raddr2];
    assign rdata3 = (we && waddr == raddr3) ? wdata : regs[raddr3];

endmodule

/* vec_lane_alu.sv */
`timescale 1ns/1ns

`include "vec_settings.svh"

module vec_lane_alu (
    input  vec_pkg::opcode_e op,
    input  vec_pkg::vec_t    a,
    input  vec_pkg::vec_t    b,
    input  vec_pkg::lane_t   imm,
    output vec_pkg::vec_t    result
);

    vec_pkg::vec_t lane_res;

    // =====================================================================
    // Lanewise arithmetic
    // =====================================================================

    for (genvar i = 0; i < `VEC_LANES; i++) begin : g_lane
        vec_pkg::lane_t r;

        always_comb begin
            case (op)
                vec_pkg::OP_VLI: begin
                    r = imm;
                end
                vec_pkg::OP_VADD: begin
                    r = a[i] + b[i];
                end
                vec_pkg::OP_VSUB: begin
                    r = a[i] - b[i];
                end
                // Low half of the product only
                vec_pkg::OP_VMUL: begin
                    r = a[i] * b[i];
                end
                vec_pkg::OP_VMAX: begin
                    r = (a[i] > b[i]) ? a[i] : b[i];
                end
                default: begin
                    r = '0;
                end
            endcase
        end

        assign lane_res[i] = r;
    end

    // =====================================================================
    // Cross-lane permutes
    // =====================================================================

    always_comb begin
        case (op)
            vec_pkg::OP_VBCAST: begin
                result = {`VEC_LANES{a[0]}};
            end
            vec_pkg::OP_VREV: begin
                for (int i = 0; i < `VEC_LANES; i++) begin
                    result[i] = a[`VEC_LANES-1-i];
                end
            end
            default: begin
                result = lane_res;
            end
        endcase
    end

endmodule

/* vec_data_mem.sv */
`timescale 1ns/1ns

`include "vec_settings.svh"

module vec_data_mem (
    input  logic               clk,
    input  logic               rst,
    input  vec_pkg::mem_addr_t addr,
    input  logic               we,
    input  logic               re,
    input  vec_pkg::vec_t      wdata,
    output vec_pkg::vec_t      rdata
);

    vec_pkg::vec_t mem [`VEC_MEM_DEPTH];

    // One port, a whole vector per word
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `VEC_MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[addr] <= wdata;
        end
    end

    // Read data held until the next load
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata <= '0;
        end else if (re) begin
            rdata <= mem[addr];
        end
    end

endmodule

/* vec_core.sv */
`timescale 1ns/1ns

module vec_core (
    input  logic            clk,
    input  logic            rst,
    input  logic            instr_valid,
    input  vec_pkg::instr_t instr,
    output logic            instr_ready,
    output logic            wb_valid,
    output vec_pkg::wb_t    wb
);

    vec_pkg::ctrl_t      id_ctrl;
    logic                stall;
    logic                accept;
    vec_pkg::vec_t       rd1;
    vec_pkg::vec_t       rd2;
    vec_pkg::vec_t       rd3;

    vec_pkg::ex_stage_t  ex_q;
    logic                ex_valid;
    vec_pkg::vec_t       alu_result;
    vec_pkg::vec_t       mem_rdata;

    vec_pkg::mem_stage_t mem_q;
    logic                mem_valid;
    vec_pkg::vec_t       mem_result;

    // =====================================================================
    // ID
    // =====================================================================

    assign instr_ready = ~stall;
    assign accept      = instr_valid & instr_ready;

    vec_decoder i_vec_decoder (
        .instr  (instr                          ),
        .ex_vd  (ex_q.ctrl.vd                   ),
        .ex_we  (ex_valid & ex_q.ctrl.reg_we    ),
        .mem_vd (mem_q.vd                       ),
        .mem_we (mem_valid & mem_q.reg_we       ),
        .ctrl   (id_ctrl                        ),
        .stall  (stall                          )
    );

    // Port 3 reads the store source
    vec_regfile i_vec_regfile (
        .clk    (clk        ),
        .rst    (rst        ),
        .we     (wb_valid   ),
        .waddr  (wb.vd      ),
        .wdata  (wb.data    ),
        .raddr1 (id_ctrl.vs1),
        .raddr2 (id_ctrl.vs2),
        .raddr3 (id_ctrl.vd ),
        .rdata1 (rd1        ),
        .rdata2 (rd2        ),
        .rdata3 (rd3        )
    );

    // Bubble into EX while stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ex_q.ctrl <= id_ctrl;
            ex_q.a    <= rd1;
            ex_q.b    <= rd2;
            ex_q.c    <= rd3;
        end
    end

    // =====================================================================
    // EX
    // =====================================================================

    vec_lane_alu i_vec_lane_alu (
        .op     (ex_q.ctrl.opcode),
        .a      (ex_q.a          ),
        .b      (ex_q.b          ),
        .imm    (ex_q.ctrl.imm   ),
        .result (alu_result      )
    );

    vec_data_mem i_vec_data_mem (
        .clk   (clk                                    ),
        .rst   (rst                                    ),
        .addr  (vec_pkg::mem_addr_t'(ex_q.ctrl.imm)    ),
        .we    (ex_valid & ex_q.ctrl.mem_we            ),
        .re    (ex_valid & ex_q.ctrl.mem_re            ),
        .wdata (ex_q.c                                 ),
        .rdata (mem_rdata                              )
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_valid <= 1'b0;
        end else begin
            mem_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        mem_q.vd     <= ex_q.ctrl.vd;
        mem_q.reg_we <= ex_q.ctrl.reg_we;
        mem_q.mem_re <= ex_q.ctrl.mem_re;
        mem_q.result <= alu_result;
    end

    // =====================================================================
    // MEM
    // =====================================================================

    // Load data arrives registered in this stage
    assign mem_result = mem_q.mem_re ? mem_rdata : mem_q.result;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= mem_valid & mem_q.reg_we;
        end
    end

    always_ff @(posedge clk) begin
        wb.vd   <= mem_q.vd;
        wb.data <= mem_result;
    end

endmodule

/* vec_core_assert.sv */
`timescale 1ns/1ns

module vec_core_assert (
    input logic            clk,
    input logic            rst,
    input logic            instr_valid,
    input vec_pkg::instr_t instr,
    input logic            instr_ready,
    input logic            wb_valid
);

    vec_pkg::opcode_e   op;
    vec_pkg::reg_addr_t vd;
    vec_pkg::reg_addr_t vs1;
    vec_pkg::reg_addr_t vs2;
    logic               accept;
    logic               writes;
    logic               dep;
    logic               ex_w;
    logic               mem_w;
    logic               wb_w;
    vec_pkg::reg_addr_t ex_vd;
    vec_pkg::reg_addr_t mem_vd;
    logic               rst_q;
    logic               wait_q;
    vec_pkg::instr_t    instr_q;
    logic               reset_ok;
    logic               ready_ok;
    logic               latency_ok;
    logic               hold_ok;
    int                 assert_errors;

    // Register target not yet written back
    function automatic logic pending(input vec_pkg::reg_addr_t r);
        return (ex_w && ex_vd == r) || (mem_w && mem_vd == r);
    endfunction

    assign op     = vec_pkg::opcode_e'(instr[31:28]);
    assign vd     = instr[27:24];
    assign vs1    = instr[23:20];
    assign vs2    = instr[19:16];
    assign accept = instr_valid && instr_ready;
    assign writes = op inside {vec_pkg::OP_VLI, vec_pkg::OP_VADD, vec_pkg::OP_VSUB,
                               vec_pkg::OP_VMUL, vec_pkg::OP_VMAX, vec_pkg::OP_VBCAST,
                               vec_pkg::OP_VREV, vec_pkg::OP_VLOAD};

    always_comb begin
        case (op)
            vec_pkg::OP_VADD, vec_pkg::OP_VSUB, vec_pkg::OP_VMUL, vec_pkg::OP_VMAX:
                dep = pending(vs1) || pending(vs2);
            vec_pkg::OP_VBCAST, vec_pkg::OP_VREV:
                dep = pending(vs1);
            vec_pkg::OP_VSTORE:
                dep = pending(vd);
            default:
                dep = 1'b0;
        endcase
    end

    // =====================================================================
    // Shadow of accepted register writers, one bit per stage
    // =====================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_w   <= 1'b0;
            mem_w  <= 1'b0;
            wb_w   <= 1'b0;
            wait_q <= 1'b0;
        end else begin
            ex_w   <= accept && writes;
            mem_w  <= ex_w;
            wb_w   <= mem_w;
            wait_q <= instr_valid && !instr_ready;
        end
    end

    always_ff @(posedge clk) begin
        ex_vd   <= vd;
        mem_vd  <= ex_vd;
        rst_q   <= rst;
        instr_q <= instr;
    end

    assign reset_ok   = !(rst_q && !rst) || (!wb_valid && instr_ready);
    assign ready_ok   = instr_ready == !dep;
    assign latency_ok = wb_valid == wb_w;
    assign hold_ok    = !wait_q || (instr_valid && instr == instr_q);

    a_reset_state: assert property (@(posedge clk) reset_ok)
        else $error("core not idle in the first cycle after reset");
    a_ready_hazard: assert property (@(posedge clk) disable iff (rst) ready_ok)
        else $error("instr_ready disagrees with the pending register dependency");
    a_wb_latency: assert property (@(posedge clk) disable iff (rst) latency_ok)
        else $error("wb_valid not exactly 3 cycles after a register writer");
    a_instr_hold: assert property (@(posedge clk) disable iff (rst) hold_ok)
        else $error("instruction changed or dropped while waiting for ready");

    always_ff @(posedge clk) begin
        if (rst) begin
            assert_errors <= 0;
        end else if (!(reset_ok && ready_ok && latency_ok && hold_ok)) begin
            assert_errors <= assert_errors + 1;
        end
    end

endmodule

/* tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
    end

    // 4 ns period
    always #2 clk = ~clk;

endmodule

/* tb_vec_core.sv */
`timescale 1ns/1ns

`include "vec_settings.svh"

module tb_vec_core;

    localparam int NUM_INSTR      = 28;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 8 + 50;

    logic            clk;
    logic            rst;
    logic            instr_valid;
    vec_pkg::instr_t instr;
    logic            instr_ready;
    logic            wb_valid;
    vec_pkg::wb_t    wb;

    // Architectural state, updated at acceptance
    vec_pkg::vec_t model_regs [`VEC_REGS];
    vec_pkg::vec_t model_mem [`VEC_MEM_DEPTH];
    vec_pkg::wb_t  exp_q [$];
    string         name_q [$];

    int seed   = 32'ha65a_a67a;
    int errors = 0;
    int checks = 0;
    int cycles = 0;

    tb_clock i_tb_clock (.clk(clk), .rst(rst));

    vec_core i_vec_core (
        .clk         (clk        ),
        .rst         (rst        ),
        .instr_valid (instr_valid),
        .instr       (instr      ),
        .instr_ready (instr_ready),
        .wb_valid    (wb_valid   ),
        .wb          (wb         )
    );

    bind vec_core vec_core_assert i_vec_core_assert (
        .clk         (clk        ),
        .rst         (rst        ),
        .instr_valid (instr_valid),
        .instr       (instr      ),
        .instr_ready (instr_ready),
        .wb_valid    (wb_valid   )
    );

    function automatic vec_pkg::instr_t encode(input vec_pkg::opcode_e op, input int vd,
                                               input int vs1, input int vs2,
                                               input vec_pkg::lane_t imm);
        return {op, vec_pkg::reg_addr_t'(vd), vec_pkg::reg_addr_t'(vs1),
                vec_pkg::reg_addr_t'(vs2), imm};
    endfunction

    function automatic vec_pkg::lane_t rand_lane();
        return vec_pkg::lane_t'($random(seed));
    endfunction

    task automatic model_accept(input vec_pkg::instr_t word, input string name);
        vec_pkg::opcode_e   op;
        vec_pkg::reg_addr_t vd;
        vec_pkg::mem_addr_t addr;
        vec_pkg::vec_t      a;
        vec_pkg::vec_t      b;
        vec_pkg::wb_t       e;
        op   = vec_pkg::opcode_e'(word[31:28]);
        vd   = word[27:24];
        addr = word[7:0];
        a    = model_regs[word[23:20]];
        b    = model_regs[word[19:16]];
        e.vd = vd;
        for (int i = 0; i < `VEC_LANES; i++) begin
            case (op)
                vec_pkg::OP_VLI:    e.data[i] = word[15:0];
                vec_pkg::OP_VADD:   e.data[i] = a[i] + b[i];
                vec_pkg::OP_VSUB:   e.data[i] = a[i] - b[i];
                vec_pkg::OP_VMUL:   e.data[i] = a[i] * b[i];
                vec_pkg::OP_VMAX:   e.data[i] = (a[i] > b[i]) ? a[i] : b[i];
                vec_pkg::OP_VBCAST: e.data[i] = a[0];
                vec_pkg::OP_VREV:   e.data[i] = a[`VEC_LANES-1-i];
                vec_pkg::OP_VLOAD:  e.data[i] = model_mem[addr][i];
                default:            e.data[i] = '0;
            endcase
        end
        if (op == vec_pkg::OP_VSTORE) begin
            model_mem[addr] = model_regs[vd];
        end else if (op != vec_pkg::OP_NOP) begin
            model_regs[vd] = e.data;
            exp_q.push_back(e);
            name_q.push_back(name);
        end
    endtask

    // Holds the word until accepted, then idles up to max_gap cycles
    task automatic send(input vec_pkg::instr_t word, input string name, input int max_gap);
        int gap;
        instr_valid = 1'b1;
        instr       = word;
        @(posedge clk);
        while (!instr_ready) @(posedge clk);
        model_accept(word, name);
        #1;
        instr_valid = 1'b0;
        instr       = '0;
        gap = (max_gap > 0) ? {$random(seed)} % (max_gap + 1) : 0;
        if (gap > 0) begin
            repeat (gap) @(posedge clk);
            #1;
        end
    endtask

    task automatic check_writeback();
        vec_pkg::wb_t expected;
        string        name;
        checks++;
        assert (exp_q.size() > 0) else begin
            $display("writeback to v%0d arrived with no register write pending", wb.vd);
            errors++;
        end
        if (exp_q.size() > 0) begin
            expected = exp_q.pop_front();
            name     = name_q.pop_front();
            assert (wb == expected) else begin
                $display("mismatch %s: expected vd=%0d data=%h, actual vd=%0d data=%h",
                         name, expected.vd, expected.data, wb.vd, wb.data);
                errors++;
            end
        end
    endtask

    task automatic report_counts();
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
                 i_vec_core.i_vec_core_assert.assert_errors);
    endtask

    always @(posedge clk) begin
        if (!rst && wb_valid) begin
            check_writeback();
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d writebacks missing", cycles, exp_q.size());
            report_counts();
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        instr_valid = 1'b0;
        instr       = '0;
        for (int i = 0; i < `VEC_REGS; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < `VEC_MEM_DEPTH; i++) begin
            model_mem[i] = '0;
        end
        @(posedge clk);
        while (rst) @(posedge clk);
        #1;

        // =================================================================
        // Lanewise arithmetic and permutes, with random gaps
        // =================================================================
        send(encode(vec_pkg::OP_VLI, 1, 0, 0, rand_lane()), "vli_v1", 3);
        send(encode(vec_pkg::OP_VLI, 2, 0, 0, rand_lane()), "vli_v2", 3);
        send(encode(vec_pkg::OP_VLI, 3, 0, 0, rand_lane()), "vli_v3", 3);
        send(encode(vec_pkg::OP_VLI, 4, 0, 0, rand_lane()), "vli_v4", 3);
        send(encode(vec_pkg::OP_VADD, 5, 1, 2, '0), "vadd", 3);
        send(encode(vec_pkg::OP_VSUB, 6, 1, 2, '0), "vsub", 3);
        send(encode(vec_pkg::OP_VMUL, 7, 3, 4, '0), "vmul", 3);
        send(encode(vec_pkg::OP_VMAX, 8, 1, 3, '0), "vmax", 0);
        send(encode(vec_pkg::OP_VMAX, 8, 8, 4, '0), "vmax_dep", 3);
        send(encode(vec_pkg::OP_VBCAST, 9, 5, 0, '0), "vbcast", 3);
        send(encode(vec_pkg::OP_VREV, 10, 7, 0, '0), "vrev", 3);

        // Store, reload, untouched address, store of a fresh result
        send(encode(vec_pkg::OP_VSTORE, 5, 0, 0, 16'h0010), "store", 0);
        send(encode(vec_pkg::OP_VLOAD, 11, 0, 0, 16'h0010), "load_stored", 3);
        send(encode(vec_pkg::OP_VLOAD, 12, 0, 0, 16'h0020), "load_untouched", 3);
        send(encode(vec_pkg::OP_VSUB, 6, 6, 5, '0), "vsub_dep", 0);
        send(encode(vec_pkg::OP_VSTORE, 6, 0, 0, 16'h0011), "store_dep", 0);
        send(encode(vec_pkg::OP_VLOAD, 13, 0, 0, 16'h0011), "load_dep", 3);
        send(encode(vec_pkg::OP_NOP, 0, 0, 0, '0), "nop", 3);

        // =================================================================
        // Back-to-back dependent chain
        // =================================================================
        send(encode(vec_pkg::OP_VLI, 14, 0, 0, rand_lane()), "chain_vli", 0);
        send(encode(vec_pkg::OP_VADD, 14, 14, 14, '0), "chain_vadd", 0);
        send(encode(vec_pkg::OP_VMUL, 15, 14, 14, '0), "chain_vmul", 0);
        send(encode(vec_pkg::OP_VSUB, 15, 15, 14, '0), "chain_vsub", 0);
        send(encode(vec_pkg::OP_VSTORE, 15, 0, 0, 16'h0030), "chain_store", 0);
        send(encode(vec_pkg::OP_VLOAD, 0, 0, 0, 16'h0030), "chain_load", 0);
        send(encode(vec_pkg::OP_VBCAST, 1, 0, 0, '0), "chain_vbcast", 0);

        // Idle input, only the in-flight writes may retire
        repeat (12) @(posedge clk);
        #1;
        send(encode(vec_pkg::OP_VADD, 2, 1, 0, '0), "idle_vadd", 0);
        send(encode(vec_pkg::OP_VREV, 3, 2, 0, '0), "idle_vrev", 0);
        send(encode(vec_pkg::OP_VMAX, 4, 3, 12, '0), "idle_vmax", 0);

        while (exp_q.size() != 0) @(posedge clk);
        repeat (6) @(posedge clk);

        report_counts();
        if (errors == 0 && i_vec_core.i_vec_core_assert.assert_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+.
vec_pkg.sv
vec_decoder.sv
vec_regfile.sv
vec_lane_alu.sv
vec_data_mem.sv
vec_core.sv
vec_core_assert.sv
tb_clock.sv
tb_vec_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_vec_core -f build.f -o Vtb_vec_core

./obj_dir/Vtb_vec_core +verilator+error+limit+1000 | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
